/* run.sh */
#!/bin/sh
# build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_tenyr_periph -f src.f -o tb_tenyr_periph
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_tenyr_periph > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

/* source/bus_ctrl.sv */
module bus_ctrl
    import tenyr_pkg::*;
#(
    parameter int    RAM_WORDS  = 1024,
    parameter addr_t SEG_BASE   = 16'h0400,
    parameter addr_t VIDEO_BASE = 16'h0410
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  addr_t      wb_adr,
    output word_t      wb_dat_r,
    output logic       wb_ack,
    output logic       ram_en,
    output logic       ram_we,
    output logic       seg_we,
    output logic       mmr_we,
    output logic [1:0] mmr_idx,
    input  word_t      ram_rdata,
    input  word_t      seg_rdata,
    input  word_t      mmr_rdata
);

    localparam addr_t RAM_TOP = addr_t'(RAM_WORDS);

    bus_state_t state;
    region_t    region;        // latched at acceptance
    region_t    region_dec;
    addr_t      video_off;
    logic       req;
    logic       in_access;

    assign req       = wb_cyc && wb_stb;
    assign in_access = (state == bus_access);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign video_off = wb_adr - VIDEO_BASE;

    always_comb begin
        region_dec = sel_none;
        if (wb_adr < RAM_TOP)
            region_dec = sel_ram;
        else if (wb_adr == SEG_BASE)
            region_dec = sel_seg;
        else if (wb_adr >= VIDEO_BASE && video_off < 16'd4)
            region_dec = sel_mmr;    // four slots, last one unmapped
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= bus_idle;
            region <= sel_none;
        end else begin
            case (state)
                bus_idle: begin
                    if (req) begin
                        state  <= bus_access;
                        region <= region_dec;
                    end
                end
                bus_access: begin
                    // master gave up, nothing to acknowledge
                    state <= req ? bus_ack : bus_idle;
                end
                default: state <= bus_idle;    // one ack cycle only
            endcase
        end
    end

    // register index rides along with the region
    always_ff @(posedge clk) begin
        if (state == bus_idle && req)
            mmr_idx <= video_off[1:0];
    end

    // one strobe per transaction, all in bus_access
    assign ram_en = in_access && (region == sel_ram);
    assign ram_we = ram_en && wb_we;
    assign seg_we = in_access && (region == sel_seg) && wb_we;
    assign mmr_we = in_access && (region == sel_mmr) && wb_we;

    assign wb_ack = (state == bus_ack);

    // read data valid only with ack
    always_comb begin
        wb_dat_r = '0;
        if (state == bus_ack) begin
            case (region)
                sel_ram: wb_dat_r = ram_rdata;
                sel_seg: wb_dat_r = seg_rdata;
                sel_mmr: wb_dat_r = mmr_rdata;
                default: wb_dat_r = '0;
            endcase
        end
    end

endmodule

/* source/data_ram.sv */
module data_ram
    import tenyr_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         clk,
    input  logic                         en,
    input  logic                         we,
    input  logic [$clog2(RAM_WORDS)-1:0] addr,
    input  word_t                        wdata,
    output word_t                        rdata
);

    word_t mem [RAM_WORDS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // single port, write first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
                rdata     <= wdata;    // new word shows on the read port
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* source/mmr_bank.sv */
module mmr_bank
    import tenyr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       we,
    input  logic [1:0] idx,
    input  word_t      wdata,
    output word_t      rdata,
    output reg8_t      vga_ctl,
    output reg8_t      crx,
    output reg8_t      cry
);

    // power-up state the renderer expects
    localparam reg8_t CTL_DEFAULT = 8'hF7;
    localparam reg8_t CRX_DEFAULT = 8'h01;    // cursor x is 1-based
    localparam reg8_t CRY_DEFAULT = 8'h00;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            vga_ctl <= CTL_DEFAULT;
            crx     <= CRX_DEFAULT;
            cry     <= CRY_DEFAULT;
        end else if (we) begin
            case (idx)
                2'd0:    vga_ctl <= wdata[7:0];
                2'd1:    crx     <= wdata[7:0];
                2'd2:    cry     <= wdata[7:0];
                default: ;    // slot 3 drops writes
            endcase
        end
    end

    // readback, zero extended
    always_comb begin
        case (idx)
            2'd0:    rdata = {24'b0, vga_ctl};
            2'd1:    rdata = {24'b0, crx};
            2'd2:    rdata = {24'b0, cry};
            default: rdata = '0;
        endcase
    end

endmodule

/* source/scan_timer.sv */
module scan_timer
    import tenyr_pkg::*;
#(
    parameter int SCAN_DIV = 8
) (
    input  logic   clk,
    input  logic   reset,
    output digit_t digit
);

    localparam int PW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [PW-1:0] PRE_LAST = PW'(SCAN_DIV - 1);

    logic [PW-1:0] prescale;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // prescaler and digit counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            prescale <= '0;
            digit    <= '0;
        end else if (prescale == PRE_LAST) begin
            prescale <= '0;
            digit    <= digit + 2'd1;    // wraps 3 -> 0
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

/* source/seg7_display.sv */
module seg7_display
    import tenyr_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   we,
    input  word_t  wdata,
    output word_t  rdata,
    input  digit_t digit,
    output seg_t   seg,
    output anode_t an
);

    logic [15:0] value;    // four hex digits
    logic [3:0]  nibble;

    // hex to segments, active low, dp off
    function automatic seg_t hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0:    hex_to_seg = 8'hC0;
            4'h1:    hex_to_seg = 8'hF9;
            4'h2:    hex_to_seg = 8'hA4;
            4'h3:    hex_to_seg = 8'hB0;
            4'h4:    hex_to_seg = 8'h99;
            4'h5:    hex_to_seg = 8'h92;
            4'h6:    hex_to_seg = 8'h82;
            4'h7:    hex_to_seg = 8'hF8;
            4'h8:    hex_to_seg = 8'h80;
            4'h9:    hex_to_seg = 8'h90;
            4'hA:    hex_to_seg = 8'h88;
            4'hB:    hex_to_seg = 8'h83;
            4'hC:    hex_to_seg = 8'hC6;
            4'hD:    hex_to_seg = 8'hA1;
            4'hE:    hex_to_seg = 8'h86;
            default: hex_to_seg = 8'h8E;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset)
            value <= '0;
        else if (we)
            value <= wdata[15:0];
    end

    assign rdata  = {16'b0, value};
    assign nibble = value[4*digit +: 4];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // digit drive, one clock behind digit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            an  <= 4'b1110;           // digit 0 lit
            seg <= hex_to_seg(4'h0);
        end else begin
            an  <= ~(anode_t'(1) << digit);
            seg <= hex_to_seg(nibble);
        end
    end

endmodule

/* source/tenyr_periph.sv */
module tenyr_periph
    import tenyr_pkg::*;
#(
    parameter int    RAM_WORDS  = 1024,
    parameter addr_t SEG_BASE   = 16'h0400,
    parameter addr_t VIDEO_BASE = 16'h0410,
    parameter int    SCAN_DIV   = 8
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   wb_cyc,
    input  logic   wb_stb,
    input  logic   wb_we,
    input  addr_t  wb_adr,
    input  word_t  wb_dat_w,
    output word_t  wb_dat_r,
    output logic   wb_ack,
    output seg_t   seg,
    output anode_t an,
    output reg8_t  vga_ctl,
    output reg8_t  crx,
    output reg8_t  cry
);

    localparam int RAM_AW = $clog2(RAM_WORDS);

    logic       ram_en;
    logic       ram_we;
    logic       seg_we;
    logic       mmr_we;
    logic [1:0] mmr_idx;
    word_t      ram_rdata;
    word_t      seg_rdata;
    word_t      mmr_rdata;
    digit_t     digit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone front end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bus_ctrl #(.RAM_WORDS(RAM_WORDS), .SEG_BASE(SEG_BASE), .VIDEO_BASE(VIDEO_BASE))
        bus (.clk(clk), .reset(reset),
             .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
             .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
             .ram_en(ram_en), .ram_we(ram_we), .seg_we(seg_we),
             .mmr_we(mmr_we), .mmr_idx(mmr_idx),
             .ram_rdata(ram_rdata), .seg_rdata(seg_rdata), .mmr_rdata(mmr_rdata));

    // address held by master for the whole access
    data_ram #(.RAM_WORDS(RAM_WORDS))
        ram (.clk(clk), .en(ram_en), .we(ram_we), .addr(wb_adr[RAM_AW-1:0]),
             .wdata(wb_dat_w), .rdata(ram_rdata));

    mmr_bank video_regs (.clk(clk), .reset(reset), .we(mmr_we), .idx(mmr_idx),
                         .wdata(wb_dat_w), .rdata(mmr_rdata),
                         .vga_ctl(vga_ctl), .crx(crx), .cry(cry));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // seven segment display
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    seg7_display seg7 (.clk(clk), .reset(reset), .we(seg_we),
                       .wdata(wb_dat_w), .rdata(seg_rdata),
                       .digit(digit), .seg(seg), .an(an));

    scan_timer #(.SCAN_DIV(SCAN_DIV))
        scan (.clk(clk), .reset(reset), .digit(digit));

endmodule

/* source/tenyr_pkg.sv */
package tenyr_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WORD_W = 32;
    localparam int ADDR_W = 16;

    typedef logic [WORD_W-1:0] word_t;    // wishbone data word
    typedef logic [ADDR_W-1:0] addr_t;    // word address, not byte

    // video control register value
    typedef logic [7:0] reg8_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // display
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0] seg_t;      // active low, bit 7 is dp
    typedef logic [3:0] anode_t;    // active low digit enables
    typedef logic [1:0] digit_t;    // scanned digit index

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        bus_idle,
        bus_access,
        bus_ack
    } bus_state_t;

    // decoded target of a transaction
    typedef enum logic [1:0] {
        sel_none,
        sel_ram,
        sel_seg,
        sel_mmr
    } region_t;

endpackage

/* src.f */
source/tenyr_pkg.sv
source/data_ram.sv
source/mmr_bank.sv
source/seg7_display.sv
source/scan_timer.sv
source/bus_ctrl.sv
source/tenyr_periph.sv
tb/tenyr_periph_asserts.sv
tb/tb_tenyr_periph.sv

/* tb/tb_tenyr_periph.sv */
module tb_tenyr_periph
    import tenyr_pkg::*;
();

    localparam int    RAM_WORDS   = 1024;
    localparam int    RAM_AW      = $clog2(RAM_WORDS);
    localparam addr_t SEG_BASE    = 16'h0400;
    localparam addr_t VIDEO_BASE  = 16'h0410;
    localparam int    SCAN_DIV    = 8;
    localparam int    ACK_TIMEOUT = 20;
    localparam int    ACK_LATENCY = 3;    // drive edge to ack, in cycles

    logic   clk, reset, wb_cyc, wb_stb, wb_we, wb_ack;
    addr_t  wb_adr;
    word_t  wb_dat_w, wb_dat_r;
    seg_t   seg;
    anode_t an;
    reg8_t  vga_ctl, crx, cry;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    word_t       model_ram [RAM_WORDS];
    reg8_t       model_regs [4];    // slot 3 stays zero
    logic [15:0] model_disp;
    seg_t        seg_table [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                                    8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

    logic [31:0] rng_state = 32'd5037;
    int          errors, failed_tests, test_count, mark;

    tenyr_periph #(
        .RAM_WORDS(RAM_WORDS), .SEG_BASE(SEG_BASE), .VIDEO_BASE(VIDEO_BASE), .SCAN_DIV(SCAN_DIV)
    ) dut (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .seg(seg), .an(an), .vga_ctl(vga_ctl), .crx(crx), .cry(cry)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 15);    // fold high bits down
    endfunction

    function automatic addr_t random_unmapped();
        logic [31:0] r;
        r = next_random();
        if (r[31])
            return addr_t'(32'(SEG_BASE) + 1 + r % 32'(VIDEO_BASE - SEG_BASE - 1));
        return addr_t'(32'(VIDEO_BASE) + 4 + r % (32'h10000 - 32'(VIDEO_BASE) - 4));
    endfunction

    function automatic word_t expected_reg(input logic [1:0] idx);
        return {24'b0, model_regs[idx]};
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wb_transfer(input logic we, input addr_t adr, input word_t wdata,
                               output word_t rdata);
        int n;
        n = 0;
        rdata = '0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(negedge clk);    // ack and data settled mid cycle
            n++;
        end while (!wb_ack && n < ACK_TIMEOUT);
        if (wb_ack) begin
            rdata = wb_dat_r;
            check_value("wb_ack latency", word_t'(n), word_t'(ACK_LATENCY));
        end else begin
            $display("no ack within %0d cycles at address %h", ACK_TIMEOUT, adr);
            errors++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_word(input addr_t adr, input word_t data);
        word_t unused;
        wb_transfer(1'b1, adr, data, unused);
    endtask

    task automatic read_expect(input addr_t adr, input word_t exp);
        word_t got;
        wb_transfer(1'b0, adr, next_random(), got);
        check_value("wb_dat_r", got, exp);
    endtask

    task automatic check_ports();
        @(negedge clk);
        check_value("vga_ctl", {24'b0, vga_ctl}, expected_reg(2'd0));
        check_value("crx", {24'b0, crx}, expected_reg(2'd1));
        check_value("cry", {24'b0, cry}, expected_reg(2'd2));
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (errors == mark) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        addr_t      ram_addrs [$];
        addr_t      a;
        addr_t      tmp;
        word_t      data;
        logic [1:0] idx;
        digit_t     d;
        logic [3:0] seen;
        logic       lit;
        int         j;

        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        errors = 0;
        failed_tests = 0;
        test_count = 0;
        mark = 0;
        model_regs = '{8'hF7, 8'h01, 8'h00, 8'h00};
        model_disp = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // reset defaults
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        @(negedge clk);
        check_value("wb_ack", {31'b0, wb_ack}, '0);
        check_value("wb_dat_r", wb_dat_r, '0);
        for (int i = 0; i < 3; i++) begin
            idx = 2'(i);
            read_expect(VIDEO_BASE + {14'b0, idx}, expected_reg(idx));
        end
        check_ports();
        end_test("reset defaults");

        for (int i = 0; i < 24; i++) begin
            a = addr_t'(next_random() % RAM_WORDS);
            data = next_random();
            write_word(a, data);
            model_ram[a[RAM_AW-1:0]] = data;
            ram_addrs.push_back(a);
        end
        for (int i = ram_addrs.size() - 1; i > 0; i--) begin    // shuffle read order
            j = int'(next_random() % 32'(i + 1));
            tmp = ram_addrs[i];
            ram_addrs[i] = ram_addrs[j];
            ram_addrs[j] = tmp;
        end
        foreach (ram_addrs[i])
            read_expect(ram_addrs[i], model_ram[ram_addrs[i][RAM_AW-1:0]]);
        end_test("ram write and read");

        for (int i = 0; i < 10; i++) begin
            data = next_random();
            idx = 2'(next_random() % 4);
            write_word(VIDEO_BASE + {14'b0, idx}, data);
            if (idx != 2'd3)
                model_regs[idx] = data[7:0];
        end
        check_ports();
        for (int i = 0; i < 4; i++) begin
            idx = 2'(i);
            read_expect(VIDEO_BASE + {14'b0, idx}, expected_reg(idx));
        end
        end_test("video registers");

        for (int i = 0; i < 12; i++) begin
            a = random_unmapped();
            write_word(a, next_random());
            read_expect(a, '0);
        end
        for (int i = 0; i < 4; i++) begin
            idx = 2'(i);
            read_expect(VIDEO_BASE + {14'b0, idx}, expected_reg(idx));
            read_expect(ram_addrs[i], model_ram[ram_addrs[i][RAM_AW-1:0]]);
        end
        check_ports();
        end_test("unmapped addresses");

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // display scan
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        data = next_random();
        write_word(SEG_BASE, data);
        model_disp = data[15:0];
        read_expect(SEG_BASE, {16'b0, model_disp});
        seen = '0;
        repeat (4 * SCAN_DIV + 2) begin
            @(negedge clk);
            lit = 1'b1;
            case (an)
                4'b1110: d = 2'd0;
                4'b1101: d = 2'd1;
                4'b1011: d = 2'd2;
                4'b0111: d = 2'd3;
                default: lit = 1'b0;
            endcase
            if (lit) begin
                seen[d] = 1'b1;
                check_value("seg", {24'b0, seg},
                            {24'b0, seg_table[4'(model_disp >> (4 * d))]});
            end
        end
        assert (seen == 4'hF) else begin
            $display("display scan did not light every digit, seen mask %b", seen);
            errors++;
        end
        end_test("display scan");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* tb/tenyr_periph_asserts.sv */
module tenyr_periph_asserts
    import tenyr_pkg::*;
#(
    parameter bit CHECK_BUS   = 1'b1,
    parameter bit CHECK_ANODE = 1'b1
) (
    input logic   clk,
    input logic   reset,
    input logic   cyc,
    input logic   stb,
    input logic   ack,
    input anode_t an
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    if (CHECK_BUS) begin : g_bus
        ack_needs_request: assert property (@(posedge clk) disable iff (reset)
            ack |-> (cyc && stb))
            else $error("ack raised without cyc and stb");

        ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
            ack |=> !ack)
            else $error("ack held for two cycles in a row");
    end

    // exactly one digit lit
    if (CHECK_ANODE) begin : g_anode
        an_one_low: assert property (@(posedge clk) disable iff (reset)
            $onehot(~an))
            else $error("anode drive is not one-hot low");
    end

endmodule

bind bus_ctrl tenyr_periph_asserts #(.CHECK_BUS(1'b1), .CHECK_ANODE(1'b0)) bus_checks (
    .clk(clk), .reset(reset), .cyc(wb_cyc), .stb(wb_stb), .ack(wb_ack), .an(4'b1110));

bind seg7_display tenyr_periph_asserts #(.CHECK_BUS(1'b0), .CHECK_ANODE(1'b1)) display_checks (
    .clk(clk), .reset(reset), .cyc(1'b0), .stb(1'b0), .ack(1'b0), .an(an));
